/* rtl/cnn_pkg.sv */
// kernel fixed at 3x3 and elements at DATA_W_D bits; data is signed and wraps on overflow
package cnn_pkg;

    // ==================================================
    // default sizes
    // ==================================================
    parameter int ICH_D    = 3;
    parameter int KX_D     = 3;
    parameter int KY_D     = 3;
    parameter int IX_D     = 7;
    parameter int IY_D     = 4;
    parameter int DATA_W_D = 8;

    // taps per kernel window
    parameter int KTAPS = KX_D * KY_D;

    // output position index width, covers OX*OY up to 16
    parameter int POS_W = 4;

    // ==================================================
    // data types
    // ==================================================
    typedef logic signed [DATA_W_D-1:0] elem_t;

    // pixels and weights, row-major, tap 0 is top-left
    typedef struct packed {
        elem_t [KTAPS-1:0] pix;
        elem_t [KTAPS-1:0] wgt;
    } window_t;

    // one window on its way into the MAC
    typedef struct packed {
        logic             valid;
        logic             first;
        logic             last;
        logic [POS_W-1:0] pos;
        window_t          win;
    } mac_req_t;

    // one kernel result, same tags as the request
    typedef struct packed {
        logic             valid;
        logic             first;
        logic             last;
        logic [POS_W-1:0] pos;
        elem_t            sum;
    } mac_res_t;

endpackage

/* rtl/input_frame_regs.sv */
// holds map and weights for a whole frame; loads only while the sequencer accepts a strobe
`timescale 1ns/1ps

module input_frame_regs
    import cnn_pkg::*;
#(
    parameter int ICH    = ICH_D,
    parameter int IX     = IX_D,
    parameter int IY     = IY_D,
    parameter int DATA_W = DATA_W_D
) (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           i_soft_reset,
    input  logic                           i_start,
    input  logic [ICH*IX*IY*DATA_W-1:0]    i_in_fmap,
    input  logic [ICH*KTAPS*DATA_W-1:0]    i_cnn_weight,
    output logic [ICH*IX*IY*DATA_W-1:0]    o_fmap,
    output logic [ICH*KTAPS*DATA_W-1:0]    o_weight
);

    // ==================================================
    // frame storage
    // ==================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_fmap   <= '0;
            o_weight <= '0;
        end else if (i_soft_reset) begin
            o_fmap   <= '0;
            o_weight <= '0;
        end else if (i_start) begin
            // snapshot at acceptance, outside may change inputs afterwards
            o_fmap   <= i_in_fmap;
            o_weight <= i_cnn_weight;
        end
    end

endmodule

/* rtl/window_sequencer.sv */
// one window per clock while busy; strobes during a frame are dropped, no handshake
`timescale 1ns/1ps

module window_sequencer
    import cnn_pkg::*;
#(
    parameter int ICH    = ICH_D,
    parameter int IX     = IX_D,
    parameter int IY     = IY_D,
    parameter int DATA_W = DATA_W_D
) (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           i_soft_reset,
    input  logic                           i_in_valid,
    input  logic [ICH*IX*IY*DATA_W-1:0]    i_fmap,
    input  logic [ICH*KTAPS*DATA_W-1:0]    i_weight,
    output logic                           o_start,
    output mac_req_t                       o_req
);

    localparam int OX   = IX - KX_D + 1;
    localparam int OY   = IY - KY_D + 1;
    localparam int CH_W = (ICH > 1) ? $clog2(ICH) : 1;
    localparam int RW_W = (OY > 1) ? $clog2(OY) : 1;
    localparam int CL_W = (OX > 1) ? $clog2(OX) : 1;

    localparam logic [CH_W-1:0] CH_LAST  = CH_W'(ICH - 1);
    localparam logic [RW_W-1:0] ROW_LAST = RW_W'(OY - 1);
    localparam logic [CL_W-1:0] COL_LAST = CL_W'(OX - 1);

    logic            busy;
    logic [CH_W-1:0] ch;
    logic [RW_W-1:0] row;
    logic [CL_W-1:0] col;
    logic            req_last;

    assign o_start  = !busy && i_in_valid;
    assign req_last = (ch == CH_LAST) && (row == ROW_LAST) && (col == COL_LAST);

    // ==================================================
    // counters, column fastest, channel slowest
    // ==================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy <= 1'b0;
            ch   <= '0;
            row  <= '0;
            col  <= '0;
        end else if (i_soft_reset) begin
            busy <= 1'b0;
            ch   <= '0;
            row  <= '0;
            col  <= '0;
        end else if (busy) begin
            if (col == COL_LAST) begin
                col <= '0;
                if (row == ROW_LAST) begin
                    row <= '0;
                    if (ch == CH_LAST) begin
                        ch <= '0;
                    end else begin
                        ch <= ch + 1'b1;
                    end
                end else begin
                    row <= row + 1'b1;
                end
            end else begin
                col <= col + 1'b1;
            end
            // final window issued this cycle
            if (req_last) begin
                busy <= 1'b0;
            end
        end else if (o_start) begin
            busy <= 1'b1;
        end
    end

    // ==================================================
    // window gather
    // ==================================================
    always_comb begin
        int pix_idx;
        int wgt_idx;
        o_req       = '0;
        o_req.valid = busy;
        o_req.first = (ch == '0);
        o_req.last  = busy && req_last;
        o_req.pos   = POS_W'(int'(row) * OX + int'(col));
        for (int ky = 0; ky < KY_D; ky++) begin
            for (int kx = 0; kx < KX_D; kx++) begin
                pix_idx = (int'(ch) * IY + int'(row) + ky) * IX + int'(col) + kx;
                wgt_idx = int'(ch) * KTAPS + ky * KX_D + kx;
                o_req.win.pix[ky*KX_D+kx] = i_fmap[pix_idx*DATA_W +: DATA_W];
                o_req.win.wgt[ky*KX_D+kx] = i_weight[wgt_idx*DATA_W +: DATA_W];
            end
        end
    end

endmodule

/* rtl/kernel_mac.sv */
// fixed one-cycle latency, accepts a window every clock; products and sum wrap to DATA_W
`timescale 1ns/1ps

module kernel_mac
    import cnn_pkg::*;
#(
    parameter int DATA_W = DATA_W_D
) (
    input  logic     clk,
    input  logic     reset_n,
    input  logic     i_soft_reset,
    input  mac_req_t i_req,
    output mac_res_t o_res
);

    logic [DATA_W-1:0] sum_d;
    logic [DATA_W-1:0] sum_q;
    logic              valid_q;
    logic              first_q;
    logic              last_q;
    logic [POS_W-1:0]  pos_q;

    // ==================================================
    // 3x3 multiply-accumulate
    // ==================================================
    always_comb begin
        sum_d = '0;
        for (int t = 0; t < KTAPS; t++) begin
            // low DATA_W bits of each product only
            sum_d = sum_d + DATA_W'(i_req.win.pix[t] * i_req.win.wgt[t]);
        end
    end

    // tags
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_q <= 1'b0;
            first_q <= 1'b0;
            last_q  <= 1'b0;
            pos_q   <= '0;
        end else if (i_soft_reset) begin
            valid_q <= 1'b0;
            first_q <= 1'b0;
            last_q  <= 1'b0;
            pos_q   <= '0;
        end else begin
            valid_q <= i_req.valid;
            first_q <= i_req.first;
            last_q  <= i_req.last;
            pos_q   <= i_req.pos;
        end
    end

    // result word, qualified by valid_q
    always_ff @(posedge clk) begin
        sum_q <= sum_d;
    end

    assign o_res = '{valid: valid_q, first: first_q, last: last_q, pos: pos_q, sum: sum_q};

endmodule

/* rtl/channel_accumulator.sv */
// expects channel 0 of a position before the others; output map held until next pulse
`timescale 1ns/1ps

module channel_accumulator
    import cnn_pkg::*;
#(
    parameter int IX     = IX_D,
    parameter int IY     = IY_D,
    parameter int DATA_W = DATA_W_D
) (
    input  logic                                       clk,
    input  logic                                       reset_n,
    input  logic                                       i_soft_reset,
    input  mac_res_t                                   i_res,
    output logic                                       o_ot_valid,
    output logic [(IX-KX_D+1)*(IY-KY_D+1)*DATA_W-1:0]  o_ot_ci_acc
);

    localparam int OX = IX - KX_D + 1;
    localparam int OY = IY - KY_D + 1;

    logic [OX*OY*DATA_W-1:0] work_map;
    logic [OX*OY*DATA_W-1:0] next_map;

    // ==================================================
    // in-place channel sum
    // ==================================================
    always_comb begin
        int base;
        base     = int'(i_res.pos) * DATA_W;
        next_map = work_map;
        if (i_res.valid) begin
            if (i_res.first) begin
                // channel 0 starts the position afresh
                next_map[base +: DATA_W] = i_res.sum;
            end else begin
                next_map[base +: DATA_W] = work_map[base +: DATA_W] + i_res.sum;
            end
        end
    end

    always_ff @(posedge clk) begin
        work_map <= next_map;
    end

    // ==================================================
    // output register and pulse
    // ==================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_ot_valid  <= 1'b0;
            o_ot_ci_acc <= '0;
        end else if (i_soft_reset) begin
            o_ot_valid  <= 1'b0;
            o_ot_ci_acc <= '0;
        end else begin
            o_ot_valid <= i_res.valid && i_res.last;
            // final window of the frame completes the map with this update
            if (i_res.valid && i_res.last) begin
                o_ot_ci_acc <= next_map;
            end
        end
    end

endmodule

/* rtl/cnn_acc_ci_top.sv */
// kernel fixed at 3x3; i_in_valid is a plain strobe, ignored while a frame is running
`timescale 1ns/1ps

module cnn_acc_ci_top
    import cnn_pkg::*;
#(
    parameter int ICH    = ICH_D,
    parameter int IX     = IX_D,
    parameter int IY     = IY_D,
    parameter int DATA_W = DATA_W_D
) (
    input  logic                                               clk,
    input  logic                                               reset_n,
    input  logic                                               i_soft_reset,
    input  logic                                               i_in_valid,
    input  logic [ICH*IX*IY*DATA_W-1:0]                        i_in_fmap,
    input  logic [ICH*KTAPS*DATA_W-1:0]                        i_cnn_weight,
    output logic                                               o_ot_valid,
    output logic [(IX-KX_D+1)*(IY-KY_D+1)*DATA_W-1:0]          o_ot_ci_acc
);

    logic [ICH*IX*IY*DATA_W-1:0] fmap_q;
    logic [ICH*KTAPS*DATA_W-1:0] weight_q;
    logic                        start;
    mac_req_t                    req;
    mac_res_t                    res;

    // ==================================================
    // frame capture
    // ==================================================
    input_frame_regs #(
        .ICH    (ICH),
        .IX     (IX),
        .IY     (IY),
        .DATA_W (DATA_W)
    ) u_input_frame_regs (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_soft_reset (i_soft_reset),
        .i_start      (start),
        .i_in_fmap    (i_in_fmap),
        .i_cnn_weight (i_cnn_weight),
        .o_fmap       (fmap_q),
        .o_weight     (weight_q)
    );

    // window issue
    window_sequencer #(
        .ICH    (ICH),
        .IX     (IX),
        .IY     (IY),
        .DATA_W (DATA_W)
    ) u_window_sequencer (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_soft_reset (i_soft_reset),
        .i_in_valid   (i_in_valid),
        .i_fmap       (fmap_q),
        .i_weight     (weight_q),
        .o_start      (start),
        .o_req        (req)
    );

    // ==================================================
    // compute and channel sum
    // ==================================================
    kernel_mac #(
        .DATA_W (DATA_W)
    ) u_kernel_mac (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_soft_reset (i_soft_reset),
        .i_req        (req),
        .o_res        (res)
    );

    channel_accumulator #(
        .IX     (IX),
        .IY     (IY),
        .DATA_W (DATA_W)
    ) u_channel_accumulator (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_soft_reset (i_soft_reset),
        .i_res        (res),
        .o_ot_valid   (o_ot_valid),
        .o_ot_ci_acc  (o_ot_ci_acc)
    );

endmodule

/* testbench/cnn_acc_ci_assertions.sv */
// bound into cnn_acc_ci_top; 3x3 kernel only, expected map taken from the inputs at acceptance
`timescale 1ns/1ps

module cnn_acc_ci_assertions
    import cnn_pkg::*;
#(
    parameter int ICH    = ICH_D,
    parameter int IX     = IX_D,
    parameter int IY     = IY_D,
    parameter int DATA_W = DATA_W_D
) (
    input logic                                      clk,
    input logic                                      reset_n,
    input logic                                      i_soft_reset,
    input logic                                      i_in_valid,
    input logic [ICH*IX*IY*DATA_W-1:0]               i_in_fmap,
    input logic [ICH*KTAPS*DATA_W-1:0]               i_cnn_weight,
    input logic                                      start,
    input logic                                      o_ot_valid,
    input logic [(IX-KX_D+1)*(IY-KY_D+1)*DATA_W-1:0] o_ot_ci_acc
);

    localparam int OX     = IX - KX_D + 1;
    localparam int OY     = IY - KY_D + 1;
    localparam int FMAP_W = ICH * IX * IY * DATA_W;
    localparam int WGT_W  = ICH * KTAPS * DATA_W;
    localparam int MAP_W  = OX * OY * DATA_W;
    localparam int N_WIN  = ICH * OX * OY;

    int               cnt;
    logic             accept;
    logic             done_q;
    logic             exp_valid;
    logic [MAP_W-1:0] exp_frame;
    logic [MAP_W-1:0] exp_out;

    logic             err_flag = 1'b0;
    logic [MAP_W-1:0] err_exp  = '0;
    logic [MAP_W-1:0] err_act  = '0;

    // sum over channels of the 3x3 products, every step wrapped to DATA_W
    function automatic logic [MAP_W-1:0] conv_map(input logic [FMAP_W-1:0] fmap,
                                                  input logic [WGT_W-1:0]  wgt);
        logic [MAP_W-1:0]           map;
        logic signed [DATA_W-1:0]   pix;
        logic signed [DATA_W-1:0]   wv;
        logic signed [2*DATA_W-1:0] prod;
        logic [DATA_W-1:0]          acc;
        int                         idx;
        map = '0;
        for (int oy = 0; oy < OY; oy++) begin
            for (int ox = 0; ox < OX; ox++) begin
                acc = '0;
                for (int c = 0; c < ICH; c++) begin
                    for (int t = 0; t < KTAPS; t++) begin
                        idx  = (c * IY + oy + t / KX_D) * IX + ox + t % KX_D;
                        pix  = fmap[idx*DATA_W +: DATA_W];
                        wv   = wgt[(c*KTAPS+t)*DATA_W +: DATA_W];
                        prod = pix * wv;
                        acc  = acc + prod[DATA_W-1:0];
                    end
                end
                map[(oy*OX+ox)*DATA_W +: DATA_W] = acc;
            end
        end
        return map;
    endfunction

    assign accept = (cnt == 0) && i_in_valid;

    // ==================================================
    // frame timing model
    // ==================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cnt       <= 0;
            done_q    <= 1'b0;
            exp_valid <= 1'b0;
            exp_frame <= '0;
            exp_out   <= '0;
        end else if (i_soft_reset) begin
            cnt       <= 0;
            done_q    <= 1'b0;
            exp_valid <= 1'b0;
            exp_frame <= '0;
            exp_out   <= '0;
        end else begin
            // last window issued, result lands one edge later
            done_q    <= (cnt == 1);
            exp_valid <= done_q;
            if (done_q) begin
                exp_out <= exp_frame;
            end
            if (accept) begin
                cnt       <= N_WIN;
                exp_frame <= conv_map(i_in_fmap, i_cnn_weight);
            end else if (cnt != 0) begin
                cnt <= cnt - 1;
            end
        end
    end

    // ==================================================
    // checks
    // ==================================================
    a_start_when_idle: assert property (@(posedge clk) disable iff (!reset_n)
        start == accept)
    else begin
        err_flag = 1'b1;
        err_exp  = MAP_W'($sampled(accept));
        err_act  = MAP_W'($sampled(start));
        $error("frame start does not match a strobe while idle");
    end

    a_pulse_timing: assert property (@(posedge clk) disable iff (!reset_n)
        o_ot_valid == exp_valid)
    else begin
        err_flag = 1'b1;
        err_exp  = MAP_W'($sampled(exp_valid));
        err_act  = MAP_W'($sampled(o_ot_valid));
        $error("output pulse out of step with the accepted frame");
    end

    a_pulse_single: assert property (@(posedge clk) disable iff (!reset_n)
        o_ot_valid |=> !o_ot_valid)
    else begin
        err_flag = 1'b1;
        err_exp  = '0;
        err_act  = MAP_W'(1);
        $error("output pulse longer than one cycle");
    end

    a_map_value: assert property (@(posedge clk) disable iff (!reset_n)
        o_ot_ci_acc == exp_out)
    else begin
        err_flag = 1'b1;
        err_exp  = $sampled(exp_out);
        err_act  = $sampled(o_ot_ci_acc);
        $error("output map differs from the reference convolution");
    end

endmodule

bind cnn_acc_ci_top cnn_acc_ci_assertions #(
    .ICH    (ICH),
    .IX     (IX),
    .IY     (IY),
    .DATA_W (DATA_W)
) u_assertions (
    .clk          (clk),
    .reset_n      (reset_n),
    .i_soft_reset (i_soft_reset),
    .i_in_valid   (i_in_valid),
    .i_in_fmap    (i_in_fmap),
    .i_cnn_weight (i_cnn_weight),
    .start        (start),
    .o_ot_valid   (o_ot_valid),
    .o_ot_ci_acc  (o_ot_ci_acc)
);

/* testbench/tb_cnn_acc_ci.sv */
// default sizes only; inputs change on the falling edge, all checking sits in the bound assertions
`timescale 1ns/1ps

module tb_cnn_acc_ci
    import cnn_pkg::*;
;

    localparam int ICH    = ICH_D;
    localparam int IX     = IX_D;
    localparam int IY     = IY_D;
    localparam int DATA_W = DATA_W_D;
    localparam int OX     = IX - KX_D + 1;
    localparam int OY     = IY - KY_D + 1;
    localparam int FMAP_W = ICH * IX * IY * DATA_W;
    localparam int WGT_W  = ICH * KTAPS * DATA_W;
    localparam int MAP_W  = OX * OY * DATA_W;
    localparam int N_WIN  = ICH * OX * OY;

    localparam int SEED           = 87;
    localparam int NUM_FRAMES     = 8;
    localparam int FRAME_CYCLES   = 40;
    // 8 frames of about 40 cycles, doubled, plus reset and idle gaps
    localparam int TIMEOUT_CYCLES = (NUM_FRAMES + 2) * FRAME_CYCLES * 2 + 200;

    logic              clk;
    logic              reset_n;
    logic              i_soft_reset;
    logic              i_in_valid;
    logic [FMAP_W-1:0] i_in_fmap;
    logic [WGT_W-1:0]  i_cnn_weight;
    logic              o_ot_valid;
    logic [MAP_W-1:0]  o_ot_ci_acc;

    string test_name = "reset";
    int    cycles    = 0;

    cnn_acc_ci_top u_cnn_acc_ci_top (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_soft_reset (i_soft_reset),
        .i_in_valid   (i_in_valid),
        .i_in_fmap    (i_in_fmap),
        .i_cnn_weight (i_cnn_weight),
        .o_ot_valid   (o_ot_valid),
        .o_ot_ci_acc  (o_ot_ci_acc)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // ==================================================
    // failure handling
    // ==================================================
    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "simulation stopped after a failed check");
    endtask

    // checker raises its flag at a clock edge, report half a cycle later
    always @(negedge clk) begin
        if (u_cnn_acc_ci_top.u_assertions.err_flag) begin
            stop_with_failure($sformatf("ERROR test=%s expected=%0h actual=%0h", test_name,
                u_cnn_acc_ci_top.u_assertions.err_exp,
                u_cnn_acc_ci_top.u_assertions.err_act));
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            stop_with_failure($sformatf("run did not finish within %0d clock cycles", cycles));
        end
    end

    // ==================================================
    // stimulus helpers
    // ==================================================
    task automatic fill_random();
        for (int i = 0; i < ICH * IX * IY; i++) begin
            i_in_fmap[i*DATA_W +: DATA_W] = DATA_W'($urandom);
        end
        for (int i = 0; i < ICH * KTAPS; i++) begin
            i_cnn_weight[i*DATA_W +: DATA_W] = DATA_W'($urandom);
        end
    endtask

    task automatic fill_constant(input logic [DATA_W-1:0] value);
        for (int i = 0; i < ICH * IX * IY; i++) begin
            i_in_fmap[i*DATA_W +: DATA_W] = value;
        end
        for (int i = 0; i < ICH * KTAPS; i++) begin
            i_cnn_weight[i*DATA_W +: DATA_W] = value;
        end
    endtask

    // one-cycle strobe, called just after a falling edge
    task automatic send_strobe();
        i_in_valid = 1'b1;
        @(negedge clk);
        i_in_valid = 1'b0;
    endtask

    task automatic wait_pulse();
        do begin
            @(negedge clk);
        end while (!o_ot_valid);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // ==================================================
    // test sequence
    // ==================================================
    initial begin
        void'($urandom(SEED));
        reset_n      = 1'b0;
        i_soft_reset = 1'b0;
        i_in_valid   = 1'b0;
        i_in_fmap    = '0;
        i_cnn_weight = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        // output must stay quiet before the first frame
        idle_cycles(5);

        test_name = "random";
        for (int f = 0; f < 4; f++) begin
            fill_random();
            send_strobe();
            wait_pulse();
            idle_cycles(4);
        end

        // every product wraps
        test_name = "saturated";
        fill_constant(8'h7f);
        send_strobe();
        wait_pulse();
        idle_cycles(4);

        test_name = "busy_strobe";
        fill_random();
        send_strobe();
        idle_cycles(6);
        fill_random();
        send_strobe();
        idle_cycles(3);
        fill_constant(8'h80);
        wait_pulse();
        idle_cycles(4);

        test_name = "soft_reset_abort";
        fill_random();
        send_strobe();
        idle_cycles(10);
        i_soft_reset = 1'b1;
        @(negedge clk);
        i_soft_reset = 1'b0;
        // long enough for the abandoned frame's pulse to have shown up
        idle_cycles(N_WIN + 6);

        test_name = "after_soft_reset";
        fill_random();
        send_strobe();
        wait_pulse();
        idle_cycles(4);

        if (!u_cnn_acc_ci_top.u_assertions.err_flag) begin
            $display("** PASS **");
            $finish;
        end else begin
            stop_with_failure("a check failed before the end of the run");
        end
    end

endmodule

/* verilog.f */
rtl/cnn_pkg.sv
rtl/input_frame_regs.sv
rtl/window_sequencer.sv
rtl/kernel_mac.sv
rtl/channel_accumulator.sv
rtl/cnn_acc_ci_top.sv
testbench/cnn_acc_ci_assertions.sv
testbench/tb_cnn_acc_ci.sv

/* Makefile */
# Verilator flow for the convolution layer testbench

VERILATOR ?= verilator
TOP       ?= tb_cnn_acc_ci
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIMFLAGS  ?= +verilator+error+limit+100
PASS_MSG  := ** PASS **

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only if the pass message shows up in its output
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP) $(SIMFLAGS) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
